/* verilog/hwpe_pkg.sv */
// Shared sizes, register map, engine ids and bus structs, imported by every subsystem module
package hwpe_pkg;

  localparam int unsigned N_CORES = 4;
  localparam int unsigned N_HWPES = 2;
  localparam int unsigned SEL_W   = 1;
  localparam int unsigned ID_W    = 4;

  // Selector values
  localparam logic [SEL_W-1:0] ENG_SCALE = 1'b0;
  localparam logic [SEL_W-1:0] ENG_SUM   = 1'b1;

  // Register map of each engine, byte offsets
  localparam logic [7:0] REG_TRIGGER = 8'h00;
  localparam logic [7:0] REG_STATUS  = 8'h04;
  localparam logic [7:0] REG_SRC     = 8'h08;
  localparam logic [7:0] REG_DST     = 8'h0C;
  localparam logic [7:0] REG_LEN     = 8'h10;
  localparam logic [7:0] REG_SCALAR  = 8'h14;

  // Config bus, wen high means read
  typedef struct packed {
    logic            req;
    logic [7:0]      add;
    logic            wen;
    logic [3:0]      be;
    logic [31:0]     data;
    logic [ID_W-1:0] id;
  } periph_req_t;

  typedef struct packed {
    logic            gnt;
    logic            r_valid;
    logic [31:0]     r_data;
    logic [ID_W-1:0] r_id;
  } periph_rsp_t;

  // Memory master port, wen high means read
  typedef struct packed {
    logic        req;
    logic        wen;
    logic [31:0] add;
    logic [31:0] data;
    logic [3:0]  be;
  } tcdm_req_t;

  typedef struct packed {
    logic        gnt;
    logic        r_valid;
    logic [31:0] r_data;
  } tcdm_rsp_t;

  typedef struct packed {
    logic [31:0] src;
    logic [31:0] dst;
    logic [15:0] len;
    logic [31:0] scalar;
  } job_t;

endpackage

/* verilog/tc_clk_gating.sv */
// Glitch-free clock gate cell, one per engine, with a test override that forces it open
`timescale 1ns/100ps

module tc_clk_gating (
  input  logic clk_i,
  input  logic en_i,
  input  logic test_en_i,
  output logic clk_o
);

  logic en_latch;

  // Transparent while the clock is low, so the enable settles before the rising edge
  always_latch begin
    if (!clk_i) begin
      en_latch <= en_i | test_en_i;
    end
  end

  assign clk_o = clk_i & en_latch;

endmodule

/* verilog/hwpe_ctrl_regs.sv */
// Engine register file on the config bus; holds the job and turns trigger and done into pulses
`timescale 1ns/100ps

module hwpe_ctrl_regs (
  input  logic                         clk,
  input  logic                         rst_n_i,
  input  hwpe_pkg::periph_req_t        periph_req_i,
  output hwpe_pkg::periph_rsp_t        periph_rsp_o,
  input  logic                         busy_i,
  input  logic                         done_i,
  output hwpe_pkg::job_t               job_o,
  output logic                         start_o,
  output logic [hwpe_pkg::N_CORES-1:0] evt_o
);
  import hwpe_pkg::*;

  logic               wr_en;
  logic               rd_en;
  logic [31:0]        rd_data;
  logic               r_valid_q;
  logic [31:0]        r_data_q;
  logic [ID_W-1:0]    r_id_q;
  logic               start_q;
  logic [N_CORES-1:0] evt_q;
  job_t               job_q;

  assign wr_en = periph_req_i.req & ~periph_req_i.wen;
  assign rd_en = periph_req_i.req & periph_req_i.wen;

  // Read decode, trigger and unknown offsets read as zero
  always_comb begin
    case (periph_req_i.add)
      REG_STATUS: rd_data = {31'd0, busy_i};
      REG_SRC:    rd_data = job_q.src;
      REG_DST:    rd_data = job_q.dst;
      REG_LEN:    rd_data = {16'd0, job_q.len};
      REG_SCALAR: rd_data = job_q.scalar;
      default:    rd_data = '0;
    endcase
  end

  // Job fields
  always_ff @(posedge clk) begin
    if (wr_en) begin
      case (periph_req_i.add)
        REG_SRC:    job_q.src    <= periph_req_i.data;
        REG_DST:    job_q.dst    <= periph_req_i.data;
        REG_LEN:    job_q.len    <= periph_req_i.data[15:0];
        REG_SCALAR: job_q.scalar <= periph_req_i.data;
        default: ;
      endcase
    end
  end

  // Response payload for the cycle after the grant
  always_ff @(posedge clk) begin
    if (periph_req_i.req) begin
      r_data_q <= rd_en ? rd_data : '0;
      r_id_q   <= periph_req_i.id;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      r_valid_q <= 1'b0;
      start_q   <= 1'b0;
      evt_q     <= '0;
    end else begin
      r_valid_q <= periph_req_i.req;
      // A trigger while busy is dropped
      start_q   <= wr_en && (periph_req_i.add == REG_TRIGGER) && !busy_i;
      evt_q     <= {N_CORES{done_i}};
    end
  end

  // Always ready, grant in the request cycle
  always_comb begin
    periph_rsp_o.gnt     = periph_req_i.req;
    periph_rsp_o.r_valid = r_valid_q;
    periph_rsp_o.r_data  = r_data_q;
    periph_rsp_o.r_id    = r_id_q;
  end

  assign job_o   = job_q;
  assign start_o = start_q;
  assign evt_o   = evt_q;

endmodule

/* verilog/scale_engine.sv */
// Vector scale engine: dst[k] = src[k] * scalar for k below len, one word in flight at a time
`timescale 1ns/100ps

module scale_engine (
  input  logic                         clk,
  input  logic                         rst_n_i,
  input  hwpe_pkg::periph_req_t        periph_req_i,
  output hwpe_pkg::periph_rsp_t        periph_rsp_o,
  output hwpe_pkg::tcdm_req_t          tcdm_req_o,
  input  hwpe_pkg::tcdm_rsp_t          tcdm_rsp_i,
  output logic                         busy_o,
  output logic [hwpe_pkg::N_CORES-1:0] evt_o
);
  import hwpe_pkg::*;

  typedef enum logic [2:0] {IDLE, READ, WAIT_DATA, WRITE, DONE} state_e;

  state_e      state_q;
  state_e      state_d;
  job_t        job;
  logic        start;
  logic        done;
  logic        last;
  logic [15:0] idx_q;
  logic [31:0] offset;
  logic [31:0] word_q;

  hwpe_ctrl_regs i_ctrl_regs (
    .clk          ( clk          ),
    .rst_n_i      ( rst_n_i      ),
    .periph_req_i ( periph_req_i ),
    .periph_rsp_o ( periph_rsp_o ),
    .busy_i       ( busy_o       ),
    .done_i       ( done         ),
    .job_o        ( job          ),
    .start_o      ( start        ),
    .evt_o        ( evt_o        )
  );

  assign offset = {14'd0, idx_q, 2'b00};
  assign last   = (idx_q == job.len - 16'd1);
  assign busy_o = (state_q != IDLE) && (state_q != DONE);
  assign done   = (state_q == DONE);

  ////////////////////////////////////////////////////////////
  // FSM and memory request
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    tcdm_req_o    = '0;
    tcdm_req_o.be = 4'hF;
    case (state_q)
      IDLE: begin
        if (start) begin
          state_d = (job.len == 16'd0) ? DONE : READ;
        end
      end
      READ: begin
        tcdm_req_o.req = 1'b1;
        tcdm_req_o.wen = 1'b1;
        tcdm_req_o.add = job.src + offset;
        if (tcdm_rsp_i.gnt) begin
          state_d = WAIT_DATA;
        end
      end
      WAIT_DATA: begin
        if (tcdm_rsp_i.r_valid) begin
          state_d = WRITE;
        end
      end
      WRITE: begin
        tcdm_req_o.req  = 1'b1;
        tcdm_req_o.add  = job.dst + offset;
        tcdm_req_o.data = word_q;
        if (tcdm_rsp_i.gnt) begin
          state_d = last ? DONE : READ;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      idx_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == IDLE) begin
        idx_q <= '0;
      end else if (state_q == WRITE && tcdm_rsp_i.gnt) begin
        idx_q <= idx_q + 16'd1;
      end
    end
  end

  // Low 32 bits of the product only
  always_ff @(posedge clk) begin
    if (state_q == WAIT_DATA && tcdm_rsp_i.r_valid) begin
      word_q <= tcdm_rsp_i.r_data * job.scalar;
    end
  end

endmodule

/* verilog/sum_engine.sv */
// Vector sum engine: adds len words from src with wrap-around and stores the sum at dst
`timescale 1ns/100ps

module sum_engine (
  input  logic                         clk,
  input  logic                         rst_n_i,
  input  hwpe_pkg::periph_req_t        periph_req_i,
  output hwpe_pkg::periph_rsp_t        periph_rsp_o,
  output hwpe_pkg::tcdm_req_t          tcdm_req_o,
  input  hwpe_pkg::tcdm_rsp_t          tcdm_rsp_i,
  output logic                         busy_o,
  output logic [hwpe_pkg::N_CORES-1:0] evt_o
);
  import hwpe_pkg::*;

  typedef enum logic [2:0] {IDLE, READ, WAIT_DATA, WRITE, DONE} state_e;

  state_e      state_q;
  state_e      state_d;
  job_t        job;
  logic        start;
  logic        done;
  logic        last;
  logic [15:0] idx_q;
  logic [31:0] acc_q;

  hwpe_ctrl_regs i_ctrl_regs (
    .clk          ( clk          ),
    .rst_n_i      ( rst_n_i      ),
    .periph_req_i ( periph_req_i ),
    .periph_rsp_o ( periph_rsp_o ),
    .busy_i       ( busy_o       ),
    .done_i       ( done         ),
    .job_o        ( job          ),
    .start_o      ( start        ),
    .evt_o        ( evt_o        )
  );

  assign last   = (idx_q == job.len - 16'd1);
  assign busy_o = (state_q != IDLE) && (state_q != DONE);
  assign done   = (state_q == DONE);

  ////////////////////////////////////////////////////////////
  // FSM and memory request
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    tcdm_req_o    = '0;
    tcdm_req_o.be = 4'hF;
    case (state_q)
      IDLE: begin
        // Empty vector still stores a zero sum
        if (start) begin
          state_d = (job.len == 16'd0) ? WRITE : READ;
        end
      end
      READ: begin
        tcdm_req_o.req = 1'b1;
        tcdm_req_o.wen = 1'b1;
        tcdm_req_o.add = job.src + {14'd0, idx_q, 2'b00};
        if (tcdm_rsp_i.gnt) begin
          state_d = WAIT_DATA;
        end
      end
      WAIT_DATA: begin
        if (tcdm_rsp_i.r_valid) begin
          state_d = last ? WRITE : READ;
        end
      end
      WRITE: begin
        tcdm_req_o.req  = 1'b1;
        tcdm_req_o.add  = job.dst;
        tcdm_req_o.data = acc_q;
        if (tcdm_rsp_i.gnt) begin
          state_d = DONE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      idx_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == IDLE) begin
        idx_q <= '0;
      end else if (state_q == WAIT_DATA && tcdm_rsp_i.r_valid) begin
        idx_q <= idx_q + 16'd1;
      end
    end
  end

  // Accumulator, cleared on each new job
  always_ff @(posedge clk) begin
    if (state_q == IDLE && start) begin
      acc_q <= '0;
    end else if (state_q == WAIT_DATA && tcdm_rsp_i.r_valid) begin
      acc_q <= acc_q + tcdm_rsp_i.r_data;
    end
  end

endmodule

/* verilog/cfg_demux.sv */
// Config bus demux: request to the selected engine only, its response, busy and events back
`timescale 1ns/100ps

module cfg_demux (
  input  logic [hwpe_pkg::SEL_W-1:0]                          sel_i,
  input  hwpe_pkg::periph_req_t                               periph_req_i,
  output hwpe_pkg::periph_rsp_t                               periph_rsp_o,
  output hwpe_pkg::periph_req_t [hwpe_pkg::N_HWPES-1:0]       eng_req_o,
  input  hwpe_pkg::periph_rsp_t [hwpe_pkg::N_HWPES-1:0]       eng_rsp_i,
  input  logic [hwpe_pkg::N_HWPES-1:0]                        eng_busy_i,
  input  logic [hwpe_pkg::N_HWPES-1:0][hwpe_pkg::N_CORES-1:0] eng_evt_i,
  output logic                                                busy_o,
  output logic [hwpe_pkg::N_CORES-1:0]                        evt_o
);
  import hwpe_pkg::*;

  // Payload fields fan out to all engines, only req is decoded
  always_comb begin
    for (int i = 0; i < N_HWPES; i++) begin
      eng_req_o[i]     = periph_req_i;
      eng_req_o[i].req = periph_req_i.req && (sel_i == SEL_W'(i));
    end
  end

  // Return path from the selected engine
  always_comb begin
    periph_rsp_o = eng_rsp_i[sel_i];
    busy_o       = eng_busy_i[sel_i];
    evt_o        = eng_evt_i[sel_i];
  end

endmodule

/* verilog/tcdm_mux_static.sv */
// Static memory channel mux: the selected engine owns the shared master port
`timescale 1ns/100ps

module tcdm_mux_static (
  input  logic [hwpe_pkg::SEL_W-1:0]                  sel_i,
  input  hwpe_pkg::tcdm_req_t [hwpe_pkg::N_HWPES-1:0] in_req_i,
  output hwpe_pkg::tcdm_rsp_t [hwpe_pkg::N_HWPES-1:0] in_rsp_o,
  output hwpe_pkg::tcdm_req_t                         out_req_o,
  input  hwpe_pkg::tcdm_rsp_t                         out_rsp_i
);
  import hwpe_pkg::*;

  assign out_req_o = in_req_i[sel_i];

  // Unselected channels see no grant and no data
  always_comb begin
    for (int i = 0; i < N_HWPES; i++) begin
      in_rsp_o[i] = (sel_i == SEL_W'(i)) ? out_rsp_i : '0;
    end
  end

endmodule

/* verilog/hwpe_subsystem.sv */
// Accelerator subsystem top: clock gates, scale and sum engines, config demux and memory mux
`timescale 1ns/100ps

module hwpe_subsystem (
  input  logic                         clk,
  input  logic                         rst_n_i,
  input  logic                         test_mode_i,
  input  logic                         hwpe_en_i,
  input  logic [hwpe_pkg::SEL_W-1:0]   hwpe_sel_i,
  input  hwpe_pkg::periph_req_t        cfg_req_i,
  output hwpe_pkg::periph_rsp_t        cfg_rsp_o,
  output hwpe_pkg::tcdm_req_t          tcdm_req_o,
  input  hwpe_pkg::tcdm_rsp_t          tcdm_rsp_i,
  output logic [hwpe_pkg::N_CORES-1:0] evt_o,
  output logic                         busy_o
);
  import hwpe_pkg::*;

  logic [N_HWPES-1:0]              hwpe_en_int;
  logic [N_HWPES-1:0]              hwpe_clk;
  logic [N_HWPES-1:0]              eng_busy;
  logic [N_HWPES-1:0][N_CORES-1:0] eng_evt;
  periph_req_t [N_HWPES-1:0]       eng_cfg_req;
  periph_rsp_t [N_HWPES-1:0]       eng_cfg_rsp;
  tcdm_req_t [N_HWPES-1:0]         eng_tcdm_req;
  tcdm_rsp_t [N_HWPES-1:0]         eng_tcdm_rsp;
  logic                            bus_en;
  periph_req_t                     cfg_req_gated;
  tcdm_req_t                       mux_req;
  tcdm_rsp_t                       mux_rsp;

  ////////////////////////////////////////////////////////////
  // Clock gates
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < N_HWPES; i++) begin : gen_clk_gate
    assign hwpe_en_int[i] = hwpe_en_i && (hwpe_sel_i == SEL_W'(i));

    tc_clk_gating i_hwpe_clock_gate (
      .clk_i     ( clk            ),
      .en_i      ( hwpe_en_int[i] ),
      .test_en_i ( test_mode_i    ),
      .clk_o     ( hwpe_clk[i]    )
    );
  end

  // A stopped engine must not see grants it cannot register
  assign bus_en = hwpe_en_i | test_mode_i;

  always_comb begin
    cfg_req_gated     = cfg_req_i;
    cfg_req_gated.req = cfg_req_i.req & bus_en;
    tcdm_req_o        = mux_req;
    tcdm_req_o.req    = mux_req.req & bus_en;
    mux_rsp           = tcdm_rsp_i;
    mux_rsp.gnt       = tcdm_rsp_i.gnt & bus_en;
  end

  ////////////////////////////////////////////////////////////
  // Engines
  ////////////////////////////////////////////////////////////

  scale_engine i_scale_engine (
    .clk          ( hwpe_clk[ENG_SCALE]     ),
    .rst_n_i      ( rst_n_i                 ),
    .periph_req_i ( eng_cfg_req[ENG_SCALE]  ),
    .periph_rsp_o ( eng_cfg_rsp[ENG_SCALE]  ),
    .tcdm_req_o   ( eng_tcdm_req[ENG_SCALE] ),
    .tcdm_rsp_i   ( eng_tcdm_rsp[ENG_SCALE] ),
    .busy_o       ( eng_busy[ENG_SCALE]     ),
    .evt_o        ( eng_evt[ENG_SCALE]      )
  );

  sum_engine i_sum_engine (
    .clk          ( hwpe_clk[ENG_SUM]     ),
    .rst_n_i      ( rst_n_i               ),
    .periph_req_i ( eng_cfg_req[ENG_SUM]  ),
    .periph_rsp_o ( eng_cfg_rsp[ENG_SUM]  ),
    .tcdm_req_o   ( eng_tcdm_req[ENG_SUM] ),
    .tcdm_rsp_i   ( eng_tcdm_rsp[ENG_SUM] ),
    .busy_o       ( eng_busy[ENG_SUM]     ),
    .evt_o        ( eng_evt[ENG_SUM]      )
  );

  // Config bus and memory port routing
  cfg_demux i_cfg_demux (
    .sel_i        ( hwpe_sel_i    ),
    .periph_req_i ( cfg_req_gated ),
    .periph_rsp_o ( cfg_rsp_o     ),
    .eng_req_o    ( eng_cfg_req   ),
    .eng_rsp_i    ( eng_cfg_rsp   ),
    .eng_busy_i   ( eng_busy      ),
    .eng_evt_i    ( eng_evt       ),
    .busy_o       ( busy_o        ),
    .evt_o        ( evt_o         )
  );

  tcdm_mux_static i_tcdm_mux (
    .sel_i     ( hwpe_sel_i   ),
    .in_req_i  ( eng_tcdm_req ),
    .in_rsp_o  ( eng_tcdm_rsp ),
    .out_req_o ( mux_req      ),
    .out_rsp_i ( mux_rsp      )
  );

endmodule

/* tests/tb_hwpe_subsystem.sv */
// Testbench for the accelerator subsystem; runs config, job, stall, isolation and select tests
`timescale 1ns/100ps

module tb_hwpe_subsystem;
  import hwpe_pkg::*;

  localparam int CYCLE_LIMIT = 4000;

  logic               clk;
  logic               rst_n_i;
  logic               test_mode;
  logic               hwpe_en;
  logic [SEL_W-1:0]   hwpe_sel;
  periph_req_t        cfg_req;
  periph_rsp_t        cfg_rsp;
  tcdm_req_t          tcdm_req;
  tcdm_rsp_t          tcdm_rsp;
  logic [N_CORES-1:0] evt;
  logic               busy;

  logic [31:0] mem [256];
  logic [31:0] img [256];
  logic [31:0] lfsr_q;
  logic        stall_en;
  logic        hold_gnt;
  logic        stall;
  logic        rd_pend;
  logic [31:0] rd_pend_data;
  logic        rvalid_q;
  logic [31:0] rdata_q;
  logic        iso_window;
  int          iso_reqs;
  int          cycles;
  logic [ID_W-1:0] next_id;
  string       cur_test;
  int          test_errs;
  int          total_errs;
  int          tests_ok;
  int          tests_bad;

  hwpe_subsystem uut (
    .clk         ( clk       ),
    .rst_n_i     ( rst_n_i   ),
    .test_mode_i ( test_mode ),
    .hwpe_en_i   ( hwpe_en   ),
    .hwpe_sel_i  ( hwpe_sel  ),
    .cfg_req_i   ( cfg_req   ),
    .cfg_rsp_o   ( cfg_rsp   ),
    .tcdm_req_o  ( tcdm_req  ),
    .tcdm_rsp_i  ( tcdm_rsp  ),
    .evt_o       ( evt       ),
    .busy_o      ( busy      )
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Done: errors found");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Random numbers and reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  function automatic logic [31:0] ref_scale(input logic [31:0] a, input logic [31:0] s);
    logic [63:0] p;
    p = {32'd0, a} * {32'd0, s};
    return p[31:0];
  endfunction

  function automatic logic [31:0] ref_sum(input int base, input int len);
    logic [31:0] acc;
    acc = '0;
    for (int k = 0; k < len; k++) begin
      acc = acc + img[base + k];
    end
    return acc;
  endfunction

  ////////////////////////////////////////////////////////////
  // Memory model
  ////////////////////////////////////////////////////////////

  assign tcdm_rsp = {tcdm_req.req & ~stall, rvalid_q, rdata_q};

  // Stall is chosen first, so the grant seen here is the one the next edge takes
  always @(negedge clk) begin
    logic [31:0] b;
    rvalid_q = rd_pend;
    rdata_q  = rd_pend_data;
    rd_pend  = 1'b0;
    if (hold_gnt) begin
      stall = 1'b1;
    end else if (stall_en) begin
      draw_bits(1, b);
      stall = b[0];
    end else begin
      stall = 1'b0;
    end
    if (tcdm_req.req && iso_window) iso_reqs++;
    if (tcdm_req.req && tcdm_req.be !== 4'hF) begin
      report_error("memory request without all byte enables set");
    end
    if (tcdm_req.req && !stall) begin
      if (tcdm_req.wen) begin
        rd_pend      = 1'b1;
        rd_pend_data = mem[tcdm_req.add[9:2]];
      end else begin
        mem[tcdm_req.add[9:2]] = tcdm_req.data;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Bus tasks and checks
  ////////////////////////////////////////////////////////////

  task automatic compare_word(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("FAIL %s %s expected %08h actual %08h", cur_test, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("%s: %s", cur_test, msg);
    test_errs++;
  endtask

  task automatic cfg_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            input int limit, output logic granted, output logic [31:0] rdata);
    logic [ID_W-1:0] id;
    int n;
    id      = next_id;
    next_id = next_id + 1'b1;
    granted = 1'b0;
    rdata   = '0;
    n       = 0;
    @(negedge clk);
    cfg_req = '{req: 1'b1, add: addr, wen: ~wr, be: 4'hF, data: wdata, id: id};
    forever begin
      #1;
      if (cfg_rsp.gnt) begin
        granted = 1'b1;
        break;
      end
      n++;
      if (n >= limit) break;
      @(negedge clk);
    end
    if (granted) begin
      @(negedge clk);
      cfg_req.req = 1'b0;
      #1;
      if (!cfg_rsp.r_valid) report_error("no r_valid one cycle after the grant");
      compare_word("r_id", 32'(id), 32'(cfg_rsp.r_id));
      rdata = cfg_rsp.r_data;
    end else begin
      cfg_req.req = 1'b0;
    end
  endtask

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] wdata);
    logic g;
    logic [31:0] d;
    cfg_access(1'b1, addr, wdata, 20, g, d);
    if (!g) report_error("register write was never granted");
  endtask

  task automatic reg_read(input logic [7:0] addr, output logic [31:0] rdata);
    logic g;
    cfg_access(1'b0, addr, '0, 20, g, rdata);
    if (!g) report_error("register read was never granted");
  endtask

  task automatic setup_job(input logic [SEL_W-1:0] eng, input int src_w, input int dst_w,
                           input int len, input logic [31:0] scalar);
    @(negedge clk);
    hwpe_sel = eng;
    reg_write(REG_SRC, 32'(src_w * 4));
    reg_write(REG_DST, 32'(dst_w * 4));
    reg_write(REG_LEN, 32'(len));
    reg_write(REG_SCALAR, scalar);
  endtask

  // Waits for the event on all cores; optionally watches busy up to it
  task automatic wait_event(input int limit, input logic check_busy);
    int n;
    int low_cnt;
    logic seen_busy;
    n = 0;
    low_cnt = 0;
    seen_busy = 1'b0;
    forever begin
      @(negedge clk);
      #1;
      if (evt == '1) break;
      if (evt != '0) report_error("event reached only some of the cores");
      if (busy) seen_busy = 1'b1;
      else if (seen_busy) low_cnt++;
      n++;
      if (n >= limit) begin
        report_error("no event before the job limit");
        break;
      end
    end
    if (check_busy && !seen_busy) report_error("busy was never seen during the job");
    if (check_busy && low_cnt > 1) report_error("busy fell well before the event");
  endtask

  task automatic fill_random(input int base, input int len);
    logic [31:0] v;
    for (int k = 0; k < len; k++) begin
      draw_bits(32, v);
      mem[base + k] = v;
    end
    img = mem;
  endtask

  task automatic check_scale(input int src_w, input int dst_w, input int len,
                             input logic [31:0] scalar);
    for (int k = 0; k < len; k++) begin
      compare_word($sformatf("dst[%0d]", k), ref_scale(img[src_w + k], scalar), mem[dst_w + k]);
    end
  endtask

  task automatic end_test;
    if (test_errs == 0) begin
      $display("%s: passed", cur_test);
      tests_ok++;
    end else begin
      $display("%s: %0d errors", cur_test, test_errs);
      tests_bad++;
    end
    total_errs += test_errs;
    test_errs = 0;
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] d;
    logic [31:0] s;
    logic g;
    int n;
    rst_n_i      = 1'b0;
    test_mode    = 1'b0;
    hwpe_en      = 1'b1;
    hwpe_sel     = ENG_SCALE;
    cfg_req      = '0;
    stall_en     = 1'b0;
    hold_gnt     = 1'b0;
    stall        = 1'b0;
    rd_pend      = 1'b0;
    rd_pend_data = '0;
    rvalid_q     = 1'b0;
    rdata_q      = '0;
    iso_window   = 1'b0;
    iso_reqs     = 0;
    cycles       = 0;
    next_id      = '0;
    lfsr_q       = 32'd85470;
    test_errs    = 0;
    total_errs   = 0;
    tests_ok     = 0;
    tests_bad    = 0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = (32'(i) * 32'h0101_0101) ^ 32'hC3C3_0000;
    end
    repeat (5) @(negedge clk);
    rst_n_i = 1'b1;

    cur_test = "reset_state";
    @(negedge clk);
    #1;
    if (busy !== 1'b0) report_error("busy is high after reset");
    if (evt !== '0) report_error("event lines are active after reset");
    if (tcdm_req.req !== 1'b0) report_error("memory request issued after reset");
    for (int e = 0; e < N_HWPES; e++) begin
      hwpe_sel = SEL_W'(e);
      reg_read(REG_STATUS, d);
      compare_word("status", 32'd0, d);
    end
    end_test();

    cur_test = "scale_basic";
    fill_random(0, 8);
    draw_bits(32, s);
    setup_job(ENG_SCALE, 0, 64, 8, s);
    reg_write(REG_TRIGGER, 32'd1);
    if (busy !== 1'b0) report_error("busy rose too early after the trigger write");
    @(negedge clk);
    #1;
    if (busy !== 1'b1) report_error("busy was not high two cycles after the trigger write");
    wait_event(200, 1'b0);
    check_scale(0, 64, 8, s);
    end_test();

    cur_test = "sum_basic";
    fill_random(128, 12);
    setup_job(ENG_SUM, 128, 192, 12, 32'd0);
    reg_write(REG_TRIGGER, 32'd1);
    wait_event(200, 1'b0);
    compare_word("sum", ref_sum(128, 12), mem[192]);
    end_test();

    cur_test = "scale_stall";
    fill_random(16, 8);
    draw_bits(32, s);
    setup_job(ENG_SCALE, 16, 80, 8, s);
    stall_en = 1'b1;
    reg_write(REG_TRIGGER, 32'd1);
    wait_event(600, 1'b1);
    stall_en = 1'b0;
    check_scale(16, 80, 8, s);
    end_test();

    cur_test = "isolation";
    fill_random(144, 12);
    setup_job(ENG_SUM, 144, 200, 12, 32'd0);
    // Memory holds the grant back so the engine waits in its first read
    hold_gnt = 1'b1;
    reg_write(REG_TRIGGER, 32'd1);
    n = 0;
    while (tcdm_req.req !== 1'b1 && n < 10) begin
      @(negedge clk);
      #1;
      n++;
    end
    if (tcdm_req.req !== 1'b1) report_error("sum engine never issued a memory request");
    // Disabled with the read request still pending
    hwpe_en = 1'b0;
    iso_window = 1'b1;
    cfg_access(1'b1, REG_SCALAR, 32'h1234, 20, g, d);
    if (g) report_error("config write was granted while the subsystem was disabled");
    @(negedge clk);
    iso_window = 1'b0;
    if (iso_reqs != 0) report_error("memory saw requests while the subsystem was disabled");
    hwpe_en = 1'b1;
    @(negedge clk);
    #1;
    hold_gnt = 1'b0;
    wait_event(200, 1'b0);
    compare_word("sum", ref_sum(144, 12), mem[200]);
    end_test();

    cur_test = "selection";
    @(negedge clk);
    // Both engine clocks run, only the demux keeps the writes apart
    test_mode = 1'b1;
    hwpe_sel = ENG_SCALE;
    reg_write(REG_SRC, 32'h0000_0A5C);
    hwpe_sel = ENG_SUM;
    reg_write(REG_SRC, 32'h0000_0F00);
    reg_write(REG_DST, 32'h0000_0E00);
    reg_write(REG_SCALAR, 32'hDEAD_0001);
    hwpe_sel = ENG_SCALE;
    reg_read(REG_SRC, d);
    compare_word("engine 0 src", 32'h0000_0A5C, d);
    test_mode = 1'b0;
    end_test();

    $display("Tests passed %0d, failed %0d, errors %0d", tests_ok, tests_bad, total_errs);
    if (total_errs == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* project.f */
verilog/hwpe_pkg.sv
verilog/tc_clk_gating.sv
verilog/hwpe_ctrl_regs.sv
verilog/scale_engine.sv
verilog/sum_engine.sv
verilog/cfg_demux.sv
verilog/tcdm_mux_static.sv
verilog/hwpe_subsystem.sv
tests/tb_hwpe_subsystem.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_hwpe_subsystem
FILELIST = project.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Done: no errors$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
